// ==== src/vga_spi_pkg.sv ====
package vga_spi_pkg;

    // ============================================================
    // Frame memory geometry
    // ============================================================
    localparam int RES_X    = 320;
    localparam int RES_Y    = 240;
    localparam int RES_DIV  = 2;
    localparam int FB_DEPTH = RES_X * RES_Y;

    // ============================================================
    // VGA 640x480 timing, counted in VGA pixels
    // ============================================================
    localparam int CLK_DIV        = 2;
    localparam int H_TOTAL        = 800;
    localparam int V_TOTAL        = 525;
    localparam int H_SYNC_LEN     = 96;
    localparam int V_SYNC_LEN     = 2;
    localparam int H_ACTIVE_START = 144;
    localparam int H_ACTIVE_END   = 783;
    localparam int V_ACTIVE_START = 35;
    localparam int V_ACTIVE_END   = 514;

    // ============================================================
    // Host command bytes
    // ============================================================
    localparam int       CMD_FLAG_BIT = 7;
    localparam bit [7:0] CMD_SWAP     = 8'h81;
    // Any other control byte behaves the same way
    localparam bit [7:0] CMD_ALIGN    = 8'h80;

    typedef logic [7:0]  byte_t;
    typedef logic [16:0] fb_addr_t;
    typedef logic [9:0]  h_count_t;
    typedef logic [9:0]  v_count_t;
    typedef logic [3:0]  color_t;

    // One write into the back bank
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        byte_t    data;
    } fb_write_t;

    // Raw counter position plus visible-area flag
    typedef struct packed {
        h_count_t h;
        v_count_t v;
        logic     active;
    } scan_pos_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
        logic   hsync;
        logic   vsync;
    } vga_out_t;

endpackage

// ==== src/spi_byte_rx.sv ====
`timescale 1ns/1ps

module spi_byte_rx
    import vga_spi_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  sclk,
    input  logic  cs_n,
    input  logic  mosi,
    output byte_t rx_data,
    output logic  rx_valid
);

    // ============================================================
    // sclk domain
    // ============================================================
    byte_t      shift_reg;
    byte_t      captured;
    logic [2:0] bit_cnt;
    logic       rdy_toggle;

    // MSB first, so the newest bit enters at the bottom
    always_ff @(posedge sclk) begin
        if (!cs_n) begin
            shift_reg <= {shift_reg[6:0], mosi};
            if (bit_cnt == 3'd7) begin
                captured <= {shift_reg[6:0], mosi};
            end
        end
    end

    always_ff @(posedge sclk or posedge rst or posedge cs_n) begin
        if (rst || cs_n) begin
            // Deselect drops any partial byte
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge sclk or posedge rst) begin
        if (rst) begin
            rdy_toggle <= 1'b0;
        end else if (!cs_n && bit_cnt == 3'd7) begin
            rdy_toggle <= ~rdy_toggle;
        end
    end

    // ============================================================
    // Crossing into clk
    // ============================================================
    logic [2:0] tog_sync;
    byte_t      data_sync1;
    byte_t      data_sync2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tog_sync <= '0;
        end else begin
            tog_sync <= {tog_sync[1:0], rdy_toggle};
        end
    end

    // Captured byte is stable long before the toggle settles
    always_ff @(posedge clk) begin
        data_sync1 <= captured;
        data_sync2 <= data_sync1;
    end

    // Toggle edge marks a fresh byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= tog_sync[1] ^ tog_sync[2];
        end
    end

    always_ff @(posedge clk) begin
        if (tog_sync[1] ^ tog_sync[2]) begin
            rx_data <= data_sync2;
        end
    end

endmodule

// ==== src/pixel_cmd_decoder.sv ====
`timescale 1ns/1ps

module pixel_cmd_decoder
    import vga_spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  byte_t     rx_data,
    input  logic      rx_valid,
    output fb_write_t fb_wr,
    output logic      swap_req
);

    // Next pixel slot in the back bank
    fb_addr_t wr_ptr;

    logic     wr_en;
    fb_addr_t wr_addr;
    byte_t    wr_data;

    logic     is_ctrl;

    assign is_ctrl = rx_data[CMD_FLAG_BIT];

    // ============================================================
    // Control state
    // ============================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            swap_req <= 1'b0;
            if (rx_valid) begin
                if (!is_ctrl) begin
                    wr_en <= 1'b1;
                    // Wrap after the last pixel of the bank
                    if (wr_ptr == fb_addr_t'(FB_DEPTH - 1)) begin
                        wr_ptr <= '0;
                    end else begin
                        wr_ptr <= wr_ptr + fb_addr_t'(1);
                    end
                end else if (rx_data == CMD_SWAP) begin
                    swap_req <= 1'b1;
                end else begin
                    wr_ptr <= '0;
                end
            end
        end
    end

    // Write payload, taken at the address before the advance
    always_ff @(posedge clk) begin
        if (rx_valid && !is_ctrl) begin
            wr_addr <= wr_ptr;
            wr_data <= rx_data;
        end
    end

    assign fb_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

// ==== src/pixel_ram.sv ====
`timescale 1ns/1ps

module pixel_ram
    import vga_spi_pkg::*;
(
    input  logic     clk,
    input  logic     we,
    input  fb_addr_t wr_addr,
    input  byte_t    wr_data,
    input  fb_addr_t rd_addr,
    output byte_t    rd_data
);

    byte_t mem [FB_DEPTH];

    // Registered read keeps this in block RAM
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer
    import vga_spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  fb_write_t fb_wr,
    input  logic      swap_req,
    input  scan_pos_t scan,
    input  logic      frame_start,
    output vga_out_t  vga
);

    // ============================================================
    // Bank select and swap
    // ============================================================
    // bank_sel picks the displayed bank, writes go to the other
    logic bank_sel;
    logic swap_pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_sel     <= 1'b0;
            swap_pending <= 1'b0;
        end else if (frame_start && swap_pending) begin
            bank_sel     <= ~bank_sel;
            swap_pending <= swap_req;
        end else if (swap_req) begin
            swap_pending <= 1'b1;
        end
    end

    logic we0;
    logic we1;

    assign we0 = fb_wr.en & bank_sel;
    assign we1 = fb_wr.en & ~bank_sel;

    // ============================================================
    // Scan address
    // ============================================================
    h_count_t h_off;
    v_count_t v_off;
    fb_addr_t col;
    fb_addr_t row;
    fb_addr_t rd_addr;

    assign h_off = scan.h - h_count_t'(H_ACTIVE_START);
    assign v_off = scan.v - v_count_t'(V_ACTIVE_START);
    // Each memory pixel covers a 2x2 block on screen
    assign col   = fb_addr_t'(h_off / RES_DIV);
    assign row   = fb_addr_t'(v_off / RES_DIV);
    assign rd_addr = scan.active ? fb_addr_t'(row * RES_X + col) : '0;

    byte_t rd_data0;
    byte_t rd_data1;
    byte_t pix;

    pixel_ram bank0 (
        .clk     (clk),
        .we      (we0),
        .wr_addr (fb_wr.addr),
        .wr_data (fb_wr.data),
        .rd_addr (rd_addr),
        .rd_data (rd_data0)
    );

    pixel_ram bank1 (
        .clk     (clk),
        .we      (we1),
        .wr_addr (fb_wr.addr),
        .wr_data (fb_wr.data),
        .rd_addr (rd_addr),
        .rd_data (rd_data1)
    );

    assign pix = bank_sel ? rd_data1 : rd_data0;

    // ============================================================
    // Output stage
    // ============================================================
    // Sync and active delayed to line up with the bank read
    logic active_d;
    logic hsync_d;
    logic vsync_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
        end else begin
            active_d <= scan.active;
            hsync_d  <= (scan.h >= h_count_t'(H_SYNC_LEN));
            vsync_d  <= (scan.v >= v_count_t'(V_SYNC_LEN));
        end
    end

    // 0b00RRGGBB, two bits per channel padded with zeros
    assign vga.r     = active_d ? {pix[5:4], 2'b00} : '0;
    assign vga.g     = active_d ? {pix[3:2], 2'b00} : '0;
    assign vga.b     = active_d ? {pix[1:0], 2'b00} : '0;
    assign vga.hsync = hsync_d;
    assign vga.vsync = vsync_d;

endmodule

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
    import vga_spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output scan_pos_t scan,
    output logic      pixel_en,
    output logic      frame_start
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    // ============================================================
    // Pixel clock enable
    // ============================================================
    logic [DIV_W-1:0] div_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (pixel_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    assign pixel_en = (div_cnt == DIV_W'(CLK_DIV - 1));

    // ============================================================
    // Horizontal and vertical counters
    // ============================================================
    h_count_t h_cnt;
    v_count_t v_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pixel_en) begin
            if (h_cnt == h_count_t'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                // End of line steps the vertical count
                if (v_cnt == v_count_t'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + v_count_t'(1);
                end
            end else begin
                h_cnt <= h_cnt + h_count_t'(1);
            end
        end
    end

    logic h_active;
    logic v_active;

    assign h_active = (h_cnt >= h_count_t'(H_ACTIVE_START)) &&
                      (h_cnt <= h_count_t'(H_ACTIVE_END));
    assign v_active = (v_cnt >= v_count_t'(V_ACTIVE_START)) &&
                      (v_cnt <= v_count_t'(V_ACTIVE_END));

    assign scan = '{h: h_cnt, v: v_cnt, active: h_active & v_active};

    // High for the whole first pixel of the frame
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

// ==== src/vga_spi_top.sv ====
`timescale 1ns/1ps

module vga_spi_top
    import vga_spi_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     sclk,
    input  logic     cs_n,
    input  logic     mosi,
    output vga_out_t vga
);

    byte_t     rx_data;
    logic      rx_valid;
    fb_write_t fb_wr;
    logic      swap_req;
    scan_pos_t scan;
    logic      frame_start;

    // SPI bytes into the clk domain
    spi_byte_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    pixel_cmd_decoder u_dec (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .fb_wr    (fb_wr),
        .swap_req (swap_req)
    );

    // Scan position and frame start for the frame buffer
    vga_timing u_timing (
        .clk         (clk),
        .rst         (rst),
        .scan        (scan),
        .pixel_en    (),
        .frame_start (frame_start)
    );

    frame_buffer u_fb (
        .clk         (clk),
        .rst         (rst),
        .fb_wr       (fb_wr),
        .swap_req    (swap_req),
        .scan        (scan),
        .frame_start (frame_start),
        .vga         (vga)
    );

endmodule

// ==== verification/vga_spi_tb.sv ====
`timescale 1ns/1ps

module vga_spi_tb
    import vga_spi_pkg::*;
();

    localparam int SPI_HALF   = 3;
    localparam int WAIT_LIMIT = 2_000_000;

    logic     clk;
    logic     rst;
    logic     sclk;
    logic     cs_n;
    logic     mosi;
    vga_out_t vga;

    vga_spi_top dut0 (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .cs_n (cs_n),
        .mosi (mosi),
        .vga  (vga)
    );

    always #2 clk = ~clk;

    // ============================================================
    // Reference model and tracked scan position
    // ============================================================
    byte_t    model_mem [2][FB_DEPTH];
    bit       bank_m;
    bit       swap_pending_m;
    int       wr_ptr_m;
    int       trk_c;
    int       trk_h;
    int       trk_v;
    int       frame_no;
    bit       locked;
    logic     vsync_prev;
    vga_out_t last_vga;
    integer   seed = 88;
    int       err_cnt;
    string    cur_test;

    // Expected output for one screen position of the shown bank
    function automatic vga_out_t expected_vga(input bit bank, input int h, input int v);
        vga_out_t e;
        byte_t    p;
        int       addr;
        e       = '0;
        e.hsync = (h >= H_SYNC_LEN);
        e.vsync = (v >= V_SYNC_LEN);
        if (h >= H_ACTIVE_START && h <= H_ACTIVE_END &&
            v >= V_ACTIVE_START && v <= V_ACTIVE_END) begin
            addr = ((v - V_ACTIVE_START) / RES_DIV) * RES_X + (h - H_ACTIVE_START) / RES_DIV;
            p    = model_mem[bank][addr];
            e.r  = {p[5:4], 2'b00};
            e.g  = {p[3:2], 2'b00};
            e.b  = {p[1:0], 2'b00};
        end
        return e;
    endfunction

    task automatic model_apply(input byte_t b);
        if (!b[CMD_FLAG_BIT]) begin
            model_mem[~bank_m][wr_ptr_m] = b;
            wr_ptr_m = (wr_ptr_m == FB_DEPTH - 1) ? 0 : wr_ptr_m + 1;
        end else if (b == CMD_SWAP) begin
            swap_pending_m = 1'b1;
        end else begin
            wr_ptr_m = 0;
        end
    endtask

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_vga(input string name, input vga_out_t expected, input vga_out_t actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Locks on the first vsync fall, then every clk is one step of the scan
    always @(negedge clk) begin
        if (locked) begin
            trk_c = (trk_c + 1) % (H_TOTAL * CLK_DIV * V_TOTAL);
        end else if (!rst && vsync_prev === 1'b1 && vga.vsync === 1'b0) begin
            locked = 1'b1;
            trk_c  = 0;
        end
        vsync_prev = vga.vsync;
        if (locked) begin
            trk_h = (trk_c % (H_TOTAL * CLK_DIV)) / CLK_DIV;
            trk_v = trk_c / (H_TOTAL * CLK_DIV);
            if (trk_c == 0) begin
                frame_no++;
                if (swap_pending_m) begin
                    bank_m         = ~bank_m;
                    swap_pending_m = 1'b0;
                end
            end
            last_vga = vga;
            check_vga(cur_test, expected_vga(bank_m, trk_h, trk_v), vga);
        end
    end

    // ============================================================
    // SPI driver and waits
    // ============================================================
    task automatic spi_send(input byte_t data, input int nbits);
        int i;
        @(posedge clk);
        cs_n <= 1'b0;
        for (i = 0; i < nbits; i++) begin
            mosi <= data[7 - i];
            repeat (SPI_HALF) @(posedge clk);
            sclk <= 1'b1;
            repeat (SPI_HALF) @(posedge clk);
            sclk <= 1'b0;
        end
        repeat (SPI_HALF) @(posedge clk);
        cs_n <= 1'b1;
        repeat (SPI_HALF) @(posedge clk);
    endtask

    task automatic send_byte(input byte_t b);
        spi_send(b, 8);
        model_apply(b);
    endtask

    task automatic send_random(input int count);
        byte_t p;
        repeat (count) begin
            p      = byte_t'($random(seed));
            p[7:6] = 2'b00;
            send_byte(p);
        end
    endtask

    task automatic wait_lock();
        int n;
        n = 0;
        while (!locked && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout: no falling edge of vsync seen");
            stop_on_failure();
        end
    endtask

    task automatic wait_frame();
        int n;
        int start;
        n     = 0;
        start = frame_no;
        while (frame_no == start && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout: no new frame started");
            stop_on_failure();
        end
    endtask

    task automatic wait_line(input int line);
        int n;
        n = 0;
        while (trk_v != line && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout: scan never reached line %0d", line);
            stop_on_failure();
        end
    endtask

    // Reads one memory pixel back from the lower right of its 2x2 block
    task automatic readback(input int addr);
        int    x;
        int    y;
        int    n;
        byte_t got;
        x = (addr % RES_X) * RES_DIV + 1;
        y = (addr / RES_X) * RES_DIV + 1;
        n = 0;
        @(posedge clk);
        while (!(trk_h == H_ACTIVE_START + x && trk_v == V_ACTIVE_START + y) &&
               n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout: scan never reached pixel %0d", addr);
            stop_on_failure();
        end else begin
            got = {2'b00, last_vga.r[3:2], last_vga.g[3:2], last_vga.b[3:2]};
            check_byte(cur_test, model_mem[bank_m][addr], got);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        sclk     = 1'b0;
        cs_n     = 1'b1;
        mosi     = 1'b0;
        cur_test = "sync_and_blanking";
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // One whole frame of sync and blanking checks
        wait_lock();
        wait_frame();

        cur_test = "write_and_swap";
        wait_line(40);
        send_byte(CMD_ALIGN);
        send_random(2 * RES_X);
        send_byte(CMD_SWAP);
        wait_frame();
        readback(0);
        readback(1);
        readback(RES_X - 1);
        readback(RES_X);
        readback(2 * RES_X - 1);

        // Old pattern must stay for the whole frame before the swap
        cur_test = "swap_at_frame_start";
        wait_line(40);
        send_byte(CMD_ALIGN);
        send_random(2 * RES_X);
        wait_frame();
        wait_line(40);
        send_byte(CMD_SWAP);
        wait_frame();
        readback(0);
        readback(RES_X + 5);

        cur_test = "address_reset";
        wait_line(40);
        send_byte(CMD_ALIGN);
        send_random(5);
        send_byte(8'h85);
        send_random(3);
        send_byte(CMD_SWAP);
        wait_frame();
        readback(0);
        readback(2);
        readback(3);
        readback(4);

        cur_test = "partial_byte";
        wait_line(40);
        send_byte(CMD_ALIGN);
        spi_send(8'h15, 5);
        send_random(4);
        send_byte(CMD_SWAP);
        wait_frame();
        readback(0);
        readback(1);
        readback(2);
        readback(3);

        if (err_cnt == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// ==== project.f ====
src/vga_spi_pkg.sv
src/spi_byte_rx.sv
src/pixel_cmd_decoder.sv
src/pixel_ram.sv
src/frame_buffer.sv
src/vga_timing.sv
src/vga_spi_top.sv
verification/vga_spi_tb.sv

// ==== Bender.yml ====
package:
  name: vga_spi

sources:
  - files:
      - src/vga_spi_pkg.sv
      - src/spi_byte_rx.sv
      - src/pixel_cmd_decoder.sv
      - src/pixel_ram.sv
      - src/frame_buffer.sv
      - src/vga_timing.sv
      - src/vga_spi_top.sv
  - target: test
    files:
      - verification/vga_spi_tb.sv
